/* source/cpu_types_pkg.sv */
/*
 * Shared definitions for the single-cycle MIPS subset: instruction field
 * widths, opcode and function codes, ALU operations
 */
`default_nettype none

package cpu_types_pkg;

    localparam int INST_WIDTH   = 32; // Instruction word
    localparam int OP_WIDTH     = 6;  // Bits 31:26
    localparam int FN_WIDTH     = 6;  // Bits 5:0, R-type only
    localparam int SHAMT_WIDTH  = 5;
    localparam int IMM_WIDTH    = 16; // I-type immediate
    localparam int TARGET_WIDTH = 26; // J-type target

    typedef enum logic [OP_WIDTH-1:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } inst_op_e;

    // R-type function field
    typedef enum logic [FN_WIDTH-1:0] {
        FN_SLL = 6'd0,
        FN_SRL = 6'd2,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } inst_fn_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

endpackage

`default_nettype wire

/* source/controller.sv */
/*
 * Main decoder: opcode and function code to datapath controls
 */
`timescale 1ns/1ns
`default_nettype none

module controller
    import cpu_types_pkg::*;
(
    input  inst_op_e i_inst_op,
    input  inst_fn_e i_inst_fn,
    output alu_op_e  o_alu_op,
    output logic     o_reg_we,     // Register write
    output logic     o_mem_we,     // Data store
    output logic     o_alu_src,    // ALU operand B from immediate
    output logic     o_reg_dst,    // Write rd instead of rt
    output logic     o_mem_to_reg, // Write-back from memory
    output logic     o_is_branch,
    output logic     o_is_jump
);

    always_comb begin
        // Defaults give a no-op
        o_alu_op     = ALU_ADD;
        o_reg_we     = 1'b0;
        o_mem_we     = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_dst    = 1'b0;
        o_mem_to_reg = 1'b0;
        o_is_branch  = 1'b0;
        o_is_jump    = 1'b0;

        case (i_inst_op)
            OP_RTYPE: begin
                o_reg_dst = 1'b1;
                o_reg_we  = 1'b1;
                case (i_inst_fn)
                    FN_ADD:  o_alu_op = ALU_ADD;
                    FN_SUB:  o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    FN_SLL:  o_alu_op = ALU_SLL;
                    FN_SRL:  o_alu_op = ALU_SRL;
                    default: o_reg_we = 1'b0; // Unknown function, nothing written
                endcase
            end
            OP_ADDI: begin
                o_alu_src = 1'b1;
                o_reg_we  = 1'b1;
            end
            OP_LW: begin
                o_alu_src    = 1'b1; // Address is rs + imm
                o_mem_to_reg = 1'b1;
                o_reg_we     = 1'b1;
            end
            OP_SW: begin
                o_alu_src = 1'b1;
                o_mem_we  = 1'b1;
            end
            OP_BEQ: begin
                o_alu_op    = ALU_SUB;
                o_is_branch = 1'b1; // Equality test is done in the datapath
            end
            OP_J: begin
                o_is_jump = 1'b1;
            end
            default: ; // Unknown opcode
        endcase
    end

endmodule

`default_nettype wire

/* source/alu.sv */
/*
 * Combinational ALU: add, subtract, and, or, signed compare, shifts
 */
`timescale 1ns/1ns
`default_nettype none

module alu
    import cpu_types_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  alu_op_e                i_op,
    input  logic [DATA_WIDTH-1:0]  i_data_a,
    input  logic [DATA_WIDTH-1:0]  i_data_b,
    input  logic [SHAMT_WIDTH-1:0] i_shamt,
    output logic [DATA_WIDTH-1:0]  o_result
);

    logic less_than; // Signed a < b

    assign less_than = $signed(i_data_a) < $signed(i_data_b);

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_data_a + i_data_b; // Wraps
            ALU_SUB: o_result = i_data_a - i_data_b;
            ALU_AND: o_result = i_data_a & i_data_b;
            ALU_OR:  o_result = i_data_a | i_data_b;
            ALU_SLT: o_result = {{(DATA_WIDTH-1){1'b0}}, less_than};
            ALU_SLL: o_result = i_data_b << i_shamt; // Shifts act on rt
            ALU_SRL: o_result = i_data_b >> i_shamt;
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_block.sv */
/*
 * General purpose register file, two read ports and one write port.
 * Register 0 is hardwired to zero
 */
`timescale 1ns/1ns
`default_nettype none

module reg_block #(
    parameter int DATA_WIDTH  = 32,
    parameter int INDEX_WIDTH = 5
) (
    input  logic                   i_Clock,
    input  logic                   i_arst_n,
    input  logic                   i_wr_enable,
    input  logic [INDEX_WIDTH-1:0] i_wr_addr,
    input  logic [INDEX_WIDTH-1:0] i_rd_addr_a,
    input  logic [INDEX_WIDTH-1:0] i_rd_addr_b,
    input  logic [DATA_WIDTH-1:0]  i_wr_data,
    output logic [DATA_WIDTH-1:0]  o_rd_data_a,
    output logic [DATA_WIDTH-1:0]  o_rd_data_b
);

    localparam int NUM_REGS = 2 ** INDEX_WIDTH;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            regs <= '{default: '0};
        end else if (i_wr_enable && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data; // Entry 0 never written
        end
    end

    // Reads see the old value during a write cycle
    assign o_rd_data_a = regs[i_rd_addr_a];
    assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

`default_nettype wire

/* source/cpu.sv */
/*
 * Single-cycle MIPS subset core: one instruction fetched, executed and
 * retired per clock
 */
`timescale 1ns/1ns
`default_nettype none

module cpu
    import cpu_types_pkg::*;
#(
    parameter int DATA_WIDTH  = 32,
    parameter int ADDR_WIDTH  = 32,
    parameter int INDEX_WIDTH = 5
) (
    input  logic                  i_Clock,
    input  logic                  i_arst_n,

    input  logic [INST_WIDTH-1:0] i_PgmInst,     // Instruction at o_PgmAddr
    output logic [ADDR_WIDTH-1:0] o_PgmAddr,

    output logic [ADDR_WIDTH-1:0] o_MemAddr,
    output logic [DATA_WIDTH-1:0] o_MemWrData,
    output logic                  o_MemWrEnable,
    input  logic [DATA_WIDTH-1:0] i_MemRdData
);

    // Instruction fields
    logic [INDEX_WIDTH-1:0]  inst_rs;
    logic [INDEX_WIDTH-1:0]  inst_rt;
    logic [INDEX_WIDTH-1:0]  inst_rd;
    logic [SHAMT_WIDTH-1:0]  inst_sh;
    logic [IMM_WIDTH-1:0]    inst_imm;
    logic [DATA_WIDTH-1:0]   inst_imm_sx; // Sign-extended immediate
    logic [TARGET_WIDTH-1:0] inst_target;
    inst_op_e                inst_op;
    inst_fn_e                inst_fn;

    always_comb begin
        inst_op     = inst_op_e'(i_PgmInst[INST_WIDTH-1 -: OP_WIDTH]);
        inst_rs     = i_PgmInst[25:21];
        inst_rt     = i_PgmInst[20:16];
        inst_rd     = i_PgmInst[15:11];
        inst_sh     = i_PgmInst[10:6];
        inst_fn     = inst_fn_e'(i_PgmInst[FN_WIDTH-1:0]);
        inst_imm    = i_PgmInst[IMM_WIDTH-1:0];
        inst_imm_sx = {{(DATA_WIDTH-IMM_WIDTH){inst_imm[IMM_WIDTH-1]}}, inst_imm};
        inst_target = i_PgmInst[TARGET_WIDTH-1:0];
    end

    alu_op_e ctrl_alu_op;
    logic    ctrl_reg_we;
    logic    ctrl_mem_we;
    logic    ctrl_alu_src;
    logic    ctrl_reg_dst;
    logic    ctrl_mem_to_reg;
    logic    ctrl_is_branch;
    logic    ctrl_is_jump;

    controller u_controller (
        .i_inst_op    (inst_op),
        .i_inst_fn    (inst_fn),
        .o_alu_op     (ctrl_alu_op),
        .o_reg_we     (ctrl_reg_we),
        .o_mem_we     (ctrl_mem_we),
        .o_alu_src    (ctrl_alu_src),
        .o_reg_dst    (ctrl_reg_dst),
        .o_mem_to_reg (ctrl_mem_to_reg),
        .o_is_branch  (ctrl_is_branch),
        .o_is_jump    (ctrl_is_jump)
    );

    logic [INDEX_WIDTH-1:0] wb_addr;   // rd for R-type, rt otherwise
    logic [DATA_WIDTH-1:0]  wb_data;
    logic [DATA_WIDTH-1:0]  rd_data_a; // rs
    logic [DATA_WIDTH-1:0]  rd_data_b; // rt
    logic [DATA_WIDTH-1:0]  alu_b;
    logic [DATA_WIDTH-1:0]  alu_result;

    assign wb_addr = ctrl_reg_dst ? inst_rd : inst_rt;
    assign wb_data = ctrl_mem_to_reg ? i_MemRdData : alu_result;
    assign alu_b   = ctrl_alu_src ? inst_imm_sx : rd_data_b;

    reg_block #(
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_reg_block (
        .i_Clock     (i_Clock),
        .i_arst_n    (i_arst_n),
        .i_wr_enable (ctrl_reg_we),
        .i_wr_addr   (wb_addr),
        .i_rd_addr_a (inst_rs),
        .i_rd_addr_b (inst_rt),
        .i_wr_data   (wb_data),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu (
        .i_op     (ctrl_alu_op),
        .i_data_a (rd_data_a),
        .i_data_b (alu_b),
        .i_shamt  (inst_sh),
        .o_result (alu_result)
    );

    logic                  rs_eq_rt;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] pc_next;
    logic [ADDR_WIDTH-1:0] pc_inc4;
    logic [ADDR_WIDTH-1:0] pc_branch;
    logic [ADDR_WIDTH-1:0] pc_jump;

    assign rs_eq_rt  = (rd_data_a == rd_data_b);
    assign pc_inc4   = pc + ADDR_WIDTH'(4);
    assign pc_branch = pc_inc4 + {inst_imm_sx[ADDR_WIDTH-3:0], 2'b00}; // Word offset
    assign pc_jump   = {pc[ADDR_WIDTH-1 -: 4], inst_target, 2'b00};

    always_comb begin
        if (ctrl_is_jump) begin
            pc_next = pc_jump;
        end else if (ctrl_is_branch && rs_eq_rt) begin
            pc_next = pc_branch;
        end else begin
            pc_next = pc_inc4; // Also for an untaken BEQ
        end
    end

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign o_PgmAddr     = pc;
    assign o_MemAddr     = alu_result;
    assign o_MemWrData   = rd_data_b;
    assign o_MemWrEnable = ctrl_mem_we & i_arst_n; // No stores while in reset

endmodule

`default_nettype wire

/* source/data_ram.sv */
/*
 * Internal data memory, word addressed, clocked write and combinational read
 */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int RAM_WORDS  = 64
) (
    input  logic                         i_Clock,
    input  logic                         i_wr_enable,
    input  logic [$clog2(RAM_WORDS)-1:0] i_word_addr,
    input  logic [DATA_WIDTH-1:0]        i_wr_data,
    output logic [DATA_WIDTH-1:0]        o_rd_data
);

    logic [DATA_WIDTH-1:0] mem [RAM_WORDS]; // Contents undefined until written

    always_ff @(posedge i_Clock) begin
        if (i_wr_enable) begin
            mem[i_word_addr] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[i_word_addr];

endmodule

`default_nettype wire

/* source/cpu_system.sv */
/*
 * Processor system: core plus internal data RAM, with the data bus split
 * by address bit 31 between RAM and an external I/O port
 */
`timescale 1ns/1ns
`default_nettype none

module cpu_system
    import cpu_types_pkg::*;
#(
    parameter int DATA_WIDTH  = 32,
    parameter int ADDR_WIDTH  = 32,
    parameter int INDEX_WIDTH = 5,
    parameter int RAM_WORDS   = 64
) (
    input  logic                  i_Clock,
    input  logic                  i_arst_n,

    input  logic [INST_WIDTH-1:0] i_PgmInst,
    output logic [ADDR_WIDTH-1:0] o_PgmAddr,

    output logic [ADDR_WIDTH-1:0] o_IoAddr,
    output logic [DATA_WIDTH-1:0] o_IoWrData,
    output logic                  o_IoWrEnable, // Sampled by the device at the clock edge
    input  logic [DATA_WIDTH-1:0] i_IoRdData
);

    localparam int WORD_BITS = $clog2(RAM_WORDS);

    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_wr_data;
    logic [DATA_WIDTH-1:0] mem_rd_data;
    logic [DATA_WIDTH-1:0] ram_rd_data;
    logic                  mem_we;
    logic                  is_io;  // Upper half of the address space
    logic                  ram_we;

    cpu #(
        .DATA_WIDTH  (DATA_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_cpu (
        .i_Clock       (i_Clock),
        .i_arst_n      (i_arst_n),
        .i_PgmInst     (i_PgmInst),
        .o_PgmAddr     (o_PgmAddr),
        .o_MemAddr     (mem_addr),
        .o_MemWrData   (mem_wr_data),
        .o_MemWrEnable (mem_we),
        .i_MemRdData   (mem_rd_data)
    );

    // Address decode
    assign is_io       = mem_addr[ADDR_WIDTH-1];
    assign ram_we      = mem_we & ~is_io;
    assign mem_rd_data = is_io ? i_IoRdData : ram_rd_data;

    data_ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .RAM_WORDS  (RAM_WORDS)
    ) u_data_ram (
        .i_Clock     (i_Clock),
        .i_wr_enable (ram_we),
        .i_word_addr (mem_addr[WORD_BITS+1:2]), // Byte address to word index
        .i_wr_data   (mem_wr_data),
        .o_rd_data   (ram_rd_data)
    );

    assign o_IoAddr     = mem_addr;
    assign o_IoWrData   = mem_wr_data;
    assign o_IoWrEnable = mem_we & is_io;

endmodule

`default_nettype wire

/* verification/tb_cpu_system.sv */
/*
 * Testbench for the processor system: random program, instruction-level
 * reference model, per-cycle checks of the PC and the I/O bus
 */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_system;

    localparam int RESET_CYCLES = 3;
    localparam int TEST_CYCLES  = 1500;
    localparam int MAX_CYCLES   = TEST_CYCLES + 500; // Margin over the test loop
    localparam int PROG_WORDS   = 256;
    localparam int RAND_START   = 95; // First word after the setup code

    logic        i_Clock = 1'b0;
    logic        i_arst_n;
    logic [31:0] i_PgmInst;
    logic [31:0] o_PgmAddr;
    logic [31:0] o_IoAddr;
    logic [31:0] o_IoWrData;
    logic        o_IoWrEnable;
    logic [31:0] i_IoRdData;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] m_pc;          // Model state
    logic [31:0] m_regs [32];
    logic [31:0] m_ram [64];
    integer      seed;
    int          checks      = 0;
    int          errors      = 0;
    int          cycle_count = 0;

    cpu_system #(
        .DATA_WIDTH  (32),
        .ADDR_WIDTH  (32),
        .INDEX_WIDTH (5),
        .RAM_WORDS   (64)
    ) dut (
        .i_Clock      (i_Clock),
        .i_arst_n     (i_arst_n),
        .i_PgmInst    (i_PgmInst),
        .o_PgmAddr    (o_PgmAddr),
        .o_IoAddr     (o_IoAddr),
        .o_IoWrData   (o_IoWrData),
        .o_IoWrEnable (o_IoWrEnable),
        .i_IoRdData   (i_IoRdData)
    );

    always #5 i_Clock = ~i_Clock;

    always @(posedge i_Clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: test loop still running after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // Memory offset off r0, RAM word or I/O space by the top bit
    function automatic logic [15:0] mem_offset(input logic [31:0] r);
        return r[31] ? {1'b1, r[12:0], 2'b00} : {8'd0, r[5:0], 2'b00};
    endfunction

    function automatic logic [5:0] pick_fn(input logic [31:0] r);
        case (r % 32'd8)
            0:       return 6'd0;  // SLL
            1:       return 6'd2;  // SRL
            2:       return 6'd32; // ADD
            3:       return 6'd34; // SUB
            4:       return 6'd36; // AND
            5:       return 6'd37; // OR
            6:       return 6'd42; // SLT
            default: return 6'd13; // Unknown, acts as a no-op
        endcase
    endfunction

    task automatic build_program();
        int          w;
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;

        // Small ADDI values so that BEQ finds equal registers often
        for (w = 0; w < 31; w++) begin
            prog[w] = {6'd8, 5'd0, 5'(w + 1), 16'({$random(seed)} % 16)};
        end
        for (w = 31; w < RAND_START; w++) begin
            prog[w] = {6'd43, 5'd0, 5'd0, 16'((w - 31) * 4)}; // Clear every RAM word
        end
        for (w = RAND_START; w < PROG_WORDS; w++) begin
            kind = {$random(seed)} % 10;
            rs   = 5'($random(seed));
            rt   = 5'($random(seed));
            rd   = 5'($random(seed));
            case (kind)
                0, 1, 2, 3: prog[w] = {6'd0, rs, rt, rd, 5'($random(seed)),
                                       pick_fn($random(seed))};
                4:          prog[w] = {6'd8, rs, rt, 16'($random(seed))};
                5:          prog[w] = {6'd35, 5'd0, rt, mem_offset($random(seed))};
                6, 7:       prog[w] = {6'd43, 5'd0, rt, mem_offset($random(seed))};
                8:          prog[w] = {6'd4, rs, rt,
                                       (($random(seed) & 1) != 0) ? 16'd8 : 16'hfff8};
                default:    prog[w] = {6'd2, 26'(RAND_START +
                                       {$random(seed)} % (PROG_WORDS - RAND_START))};
            endcase
        end
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
        if (idx != 5'd0) begin
            m_regs[idx] = value;
        end
    endtask

    // One instruction: check the bus against the model, then retire it
    task automatic step_model();
        logic [31:0] inst;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_sx;
        logic [31:0] addr;
        logic [31:0] pc_next;
        logic        io_store;

        inst     = prog[m_pc[9:2]];
        rs       = inst[25:21];
        rt       = inst[20:16];
        rd       = inst[15:11];
        sh       = inst[10:6];
        a        = m_regs[rs];
        b        = m_regs[rt];
        imm_sx   = {{16{inst[15]}}, inst[15:0]};
        addr     = a + imm_sx;
        pc_next  = m_pc + 32'd4;
        io_store = 1'b0;

        check_value("o_PgmAddr", m_pc, o_PgmAddr);
        case (inst[31:26])
            6'd0: begin
                case (inst[5:0])
                    6'd32:   write_reg(rd, a + b);
                    6'd34:   write_reg(rd, a - b);
                    6'd36:   write_reg(rd, a & b);
                    6'd37:   write_reg(rd, a | b);
                    6'd42:   write_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    6'd0:    write_reg(rd, b << sh);
                    6'd2:    write_reg(rd, b >> sh);
                    default: ;
                endcase
            end
            6'd8:  write_reg(rt, addr); // ADDI
            6'd35: begin
                if (addr[31]) begin
                    check_value("o_IoAddr", addr, o_IoAddr);
                    write_reg(rt, i_IoRdData);
                end else begin
                    write_reg(rt, m_ram[addr[7:2]]);
                end
            end
            6'd43: begin
                if (addr[31]) begin
                    io_store = 1'b1;
                    check_value("o_IoAddr", addr, o_IoAddr);
                    check_value("o_IoWrData", b, o_IoWrData);
                end else begin
                    m_ram[addr[7:2]] = b;
                end
            end
            6'd4: begin
                if (a == b) begin
                    pc_next = m_pc + 32'd4 + {imm_sx[29:0], 2'b00};
                end
            end
            6'd2:    pc_next = {m_pc[31:28], inst[25:0], 2'b00};
            default: ;
        endcase
        check_value("o_IoWrEnable", 32'(io_store), 32'(o_IoWrEnable));
        m_pc = pc_next;
    endtask

    task automatic drive_inputs();
        i_PgmInst  = prog[o_PgmAddr[9:2]];
        i_IoRdData = $random(seed);
    endtask

    initial begin
        seed       = 32'hfa49_72f1;
        i_arst_n   = 1'b0;
        i_PgmInst  = {6'd43, 5'd0, 5'd0, 16'h8000}; // SW to I/O, blocked by reset
        i_IoRdData = '0;
        build_program();
        m_pc   = '0;
        m_regs = '{default: '0};
        m_ram  = '{default: '0};

        #2;
        check_value("o_PgmAddr", 32'd0, o_PgmAddr);
        check_value("o_IoWrEnable", 32'd0, 32'(o_IoWrEnable));
        repeat (RESET_CYCLES) @(posedge i_Clock);
        #1;
        drive_inputs();
        i_arst_n = 1'b1;

        repeat (TEST_CYCLES) begin
            #4; // Outputs settled, well before the next edge
            step_model();
            @(posedge i_Clock);
            #1;
            drive_inputs();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/cpu_types_pkg.sv
source/controller.sv
source/alu.sv
source/reg_block.sv
source/cpu.sv
source/data_ram.sv
source/cpu_system.sv
verification/tb_cpu_system.sv

/* Makefile */
# Verilator build and run of the processor system testbench

SRCS := $(shell grep -v '^+' flist.f)
BIN  := obj_dir/Vtb_cpu_system

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) flist.f
	verilator --binary --assert --timescale 1ns/1ns --top-module tb_cpu_system -f flist.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
